/* list.f */
src/mm_cfg_pkg.sv
src/mm_bus_pkg.sv
src/mm_pe.sv
src/mm_systolic_array.sv
src/mm_operand_fetch.sv
src/mm_mem_arbiter.sv
src/mm_operand_mem.sv
src/mm_apb_regs.sv
src/mm_top.sv
sim/mm_clk_gen.sv
sim/mm_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module mm_tb \
  && ./obj_dir/Vmm_tb | tee /dev/stderr | grep -q "Regression passed" \
  && echo "run.sh: simulation ok" \
  || { echo "run.sh: simulation not ok"; exit 1; }

/* sim/mm_stim.txt */
// three lines per test, hex words: A columns 0-3, B rows 0-3, expected C rows 0-3
// element k of a word sits in byte k

// test 0, identity A times a general B
00000001 00000100 00010000 01000000
04030201 80FF7F10 12345678 F0E0D0C0
04030201 80FF7F10 12345678 F0E0D0C0

// test 1, products past the int8 range saturate, sums wrap
0064CE0A 039C0214 800107FD 7F050100
0100FE0D 14F80706 0002FF32 1EFF6404
897A6E77 14FDCF0F 637C7E45 BBE91311

// test 2, A rows of 1, 2, -1 and 0
00FF0201 00FF0201 00FF0201 00FF0201
04030201 80FF7F10 12345678 F0E0D0C0
8616A749 8C2CA221 79EA59B7 00000000

/* sim/mm_tb.sv */
`timescale 1ns/1ps

module mm_tb;

  localparam int NUM_TESTS      = 3;
  localparam int OPND_WORDS     = 2 * mm_cfg_pkg::MM_N;
  localparam int WORDS_PER_TEST = 3 * mm_cfg_pkg::MM_N;
  localparam int CYCLE_LIMIT    = 400 * NUM_TESTS + 200;

  logic                 clk;
  logic                 reset;
  mm_bus_pkg::apb_req_t apb_req;
  mm_bus_pkg::apb_rsp_t apb_rsp;
  logic                 irq;

  // A columns, B rows and expected C rows of each test
  logic [31:0] stim [NUM_TESTS * WORDS_PER_TEST];

  int checks;
  int errors;
  int cycle;
  int irq_count;
  int irq_cycle;
  int done_cycle;

  mm_clk_gen u_clk_gen (
    .o_clk   (clk),
    .o_reset (reset)
  );

  mm_top DUT (
    .clk   (clk),
    .reset (reset),
    .i_apb (apb_req),
    .o_apb (apb_rsp),
    .o_irq (irq)
  );

  // cycle count and run limit
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("timeout, no end of test after %0d cycles", cycle);
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("Regression failed");
      $finish;
    end
  end

  // irq is sampled mid cycle
  always @(negedge clk) begin
    if (irq === 1'b1) begin
      irq_count = irq_count + 1;
      irq_cycle = cycle;
    end
  end

  function automatic mm_bus_pkg::apb_addr_t word_addr(input mm_bus_pkg::apb_addr_t base,
                                                      input int idx);
    return base + mm_bus_pkg::apb_addr_t'(4 * idx);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAIL %s: expected %h, got %h", name, expected, actual);
    end
  endtask

  // one setup cycle and access cycles until pready
  task automatic bus_transfer(input logic write, input mm_bus_pkg::apb_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
    @(posedge clk);
    #1;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    @(negedge clk);
    while (apb_rsp.pready !== 1'b1) begin
      @(negedge clk);
    end
    rdata      = apb_rsp.prdata;
    slverr     = apb_rsp.pslverr;
    done_cycle = cycle;
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic write_word(input mm_bus_pkg::apb_addr_t addr, input logic [31:0] data,
                            output logic slverr);
    logic [31:0] unused;
    bus_transfer(1'b1, addr, data, unused, slverr);
  endtask

  task automatic read_word(input mm_bus_pkg::apb_addr_t addr, output logic [31:0] data);
    logic slverr;
    bus_transfer(1'b0, addr, 32'h0, data, slverr);
    check_value($sformatf("pslverr on read of %h", addr), 32'h0, {31'b0, slverr});
  endtask

  task automatic run_test(input int t, input bit probe_busy_read);
    int          base;
    int          runs_before;
    logic [31:0] rdata;
    logic        slverr;
    base        = t * WORDS_PER_TEST;
    runs_before = irq_count;
    for (int w = 0; w < OPND_WORDS; w++) begin
      write_word(word_addr(mm_bus_pkg::REG_OPND_BASE, w), stim[base + w], slverr);
    end
    for (int w = 0; w < OPND_WORDS; w++) begin
      read_word(word_addr(mm_bus_pkg::REG_OPND_BASE, w), rdata);
      check_value($sformatf("test%0d operand %0d", t, w), stim[base + w], rdata);
    end

    write_word(mm_bus_pkg::REG_CTRL, 32'h1, slverr);
    check_value($sformatf("test%0d start pslverr", t), 32'h0, {31'b0, slverr});
    read_word(mm_bus_pkg::REG_STATUS, rdata);
    check_value($sformatf("test%0d status busy", t), 32'h1, rdata);
    write_word(mm_bus_pkg::REG_CTRL, 32'h1, slverr);
    check_value($sformatf("test%0d start while busy", t), 32'h1, {31'b0, slverr});
    // results still hold the previous run
    if (t > 0) begin
      read_word(mm_bus_pkg::REG_RES_BASE, rdata);
      check_value($sformatf("test%0d old result row 0", t), stim[base - 4], rdata);
    end

    if (probe_busy_read) begin
      read_word(mm_bus_pkg::REG_OPND_BASE, rdata);
      check_value($sformatf("test%0d operand read in run", t), stim[base], rdata);
      checks++;
      assert (irq_count > runs_before && done_cycle > irq_cycle) else begin
        errors++;
        $display("operand read during the run completed before the run had finished");
      end
    end

    while (irq_count == runs_before) begin
      @(posedge clk);
    end
    read_word(mm_bus_pkg::REG_STATUS, rdata);
    check_value($sformatf("test%0d status done", t), 32'h2, rdata);
    read_word(mm_bus_pkg::REG_STATUS, rdata);
    check_value($sformatf("test%0d status cleared", t), 32'h0, rdata);
    check_value($sformatf("test%0d irq pulses", t), runs_before + 1, irq_count);

    for (int i = 0; i < mm_cfg_pkg::MM_N; i++) begin
      read_word(word_addr(mm_bus_pkg::REG_RES_BASE, i), rdata);
      check_value($sformatf("test%0d result row %0d", t, i), stim[base + OPND_WORDS + i],
                  rdata);
    end
  endtask

  initial begin
    logic [31:0] rdata;
    apb_req = '0;
    $readmemh("sim/mm_stim.txt", stim);
    wait (reset === 1'b0);
    @(negedge clk);
    check_value("irq after reset", 32'h0, {31'b0, irq});

    read_word(mm_bus_pkg::REG_STATUS, rdata);
    check_value("status after reset", 32'h0, rdata);
    for (int i = 0; i < mm_cfg_pkg::MM_N; i++) begin
      read_word(word_addr(mm_bus_pkg::REG_RES_BASE, i), rdata);
      check_value($sformatf("result row %0d after reset", i), 32'h0, rdata);
    end
    check_value("irq count after reset", 32'h0, irq_count);

    // identity run with a window read while busy and two more runs back to back
    run_test(0, 1'b1);
    run_test(1, 1'b0);
    run_test(2, 1'b0);

    // one pulse per run and no stray pulse in between
    check_value("irq count at end", NUM_TESTS, irq_count);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* sim/mm_clk_gen.sv */
`timescale 1ns/1ps

module mm_clk_gen (
  output logic o_clk,
  output logic o_reset
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 5;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  // release just after a rising edge
  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1 o_reset = 1'b0;
  end

endmodule

/* src/mm_top.sv */
`timescale 1ns/1ps

module mm_top (
  input  logic                 clk,
  input  logic                 reset,
  input  mm_bus_pkg::apb_req_t i_apb,
  output mm_bus_pkg::apb_rsp_t o_apb,
  output logic                 o_irq
);

  mm_bus_pkg::mem_req_t host_req;
  mm_bus_pkg::mem_req_t eng_req;
  mm_bus_pkg::mem_req_t mem_req;
  logic                 host_gnt;
  logic                 eng_gnt;
  logic                 rd_owner;
  mm_cfg_pkg::mm_lane_t rd_data;

  logic                 start;
  logic                 busy;
  logic                 clear;
  logic                 beat_valid;
  mm_cfg_pkg::mm_lane_t beat_a;
  mm_cfg_pkg::mm_lane_t beat_b;
  logic                 res_valid;
  mm_cfg_pkg::mm_res_t  res;

  mm_apb_regs u_regs (
    .clk         (clk),
    .reset       (reset),
    .i_apb       (i_apb),
    .o_apb       (o_apb),
    .o_start     (start),
    .i_busy      (busy),
    .o_host_req  (host_req),
    .i_host_gnt  (host_gnt),
    .i_rd_data   (rd_data),
    .i_rd_owner  (rd_owner),
    .i_res_valid (res_valid),
    .i_res       (res),
    .o_irq       (o_irq)
  );

  mm_mem_arbiter u_arb (
    .clk        (clk),
    .reset      (reset),
    .i_eng_req  (eng_req),
    .i_host_req (host_req),
    .o_eng_gnt  (eng_gnt),
    .o_host_gnt (host_gnt),
    .o_mem_req  (mem_req),
    .o_rd_owner (rd_owner)
  );

  mm_operand_mem u_mem (
    .clk       (clk),
    .i_req     (mem_req),
    .o_rd_data (rd_data)
  );

  mm_operand_fetch u_fetch (
    .clk          (clk),
    .reset        (reset),
    .i_start      (start),
    .o_eng_req    (eng_req),
    .i_eng_gnt    (eng_gnt),
    .i_rd_data    (rd_data),
    .o_busy       (busy),
    .o_clear      (clear),
    .o_beat_valid (beat_valid),
    .o_beat_a     (beat_a),
    .o_beat_b     (beat_b),
    .i_res_valid  (res_valid)
  );

  mm_systolic_array u_array (
    .clk          (clk),
    .reset        (reset),
    .i_beat_valid (beat_valid),
    .i_clear      (clear),
    .i_beat_a     (beat_a),
    .i_beat_b     (beat_b),
    .o_res_valid  (res_valid),
    .o_res        (res)
  );

endmodule

/* src/mm_apb_regs.sv */
`timescale 1ns/1ps

module mm_apb_regs (
  input  logic                 clk,
  input  logic                 reset,
  input  mm_bus_pkg::apb_req_t i_apb,
  output mm_bus_pkg::apb_rsp_t o_apb,
  output logic                 o_start,
  input  logic                 i_busy,
  output mm_bus_pkg::mem_req_t o_host_req,
  input  logic                 i_host_gnt,
  input  mm_cfg_pkg::mm_lane_t i_rd_data,
  input  logic                 i_rd_owner,
  input  logic                 i_res_valid,
  input  mm_cfg_pkg::mm_res_t  i_res,
  output logic                 o_irq
);

  logic                  access;
  logic                  aligned;
  logic                  hit_ctrl;
  logic                  hit_status;
  logic                  hit_opnd;
  logic                  hit_res;
  mm_bus_pkg::apb_addr_t opnd_off;
  mm_bus_pkg::apb_addr_t res_off;
  logic                  status_rd;

  logic                  done_q;
  logic                  busy_q;
  logic                  gnt_q;
  mm_cfg_pkg::mm_res_t   res_q;

  assign access  = i_apb.psel && i_apb.penable;
  assign aligned = (i_apb.paddr[1:0] == 2'b00);

  assign hit_ctrl   = (i_apb.paddr == mm_bus_pkg::REG_CTRL);
  assign hit_status = (i_apb.paddr == mm_bus_pkg::REG_STATUS);
  assign hit_opnd   = aligned && (i_apb.paddr >= mm_bus_pkg::REG_OPND_BASE) &&
                      (i_apb.paddr < mm_bus_pkg::REG_OPND_END);
  assign hit_res    = aligned && (i_apb.paddr >= mm_bus_pkg::REG_RES_BASE) &&
                      (i_apb.paddr < mm_bus_pkg::REG_RES_END);

  assign opnd_off = i_apb.paddr - mm_bus_pkg::REG_OPND_BASE;
  assign res_off  = i_apb.paddr - mm_bus_pkg::REG_RES_BASE;

  // operand window, held off for the whole run
  always_comb begin
    o_host_req       = '0;
    o_host_req.valid = access && hit_opnd && !gnt_q && !i_busy;
    o_host_req.write = i_apb.pwrite;
    o_host_req.addr  = opnd_off[2 +: mm_cfg_pkg::MM_MEM_AW];
    o_host_req.wdata = i_apb.pwdata;
  end

  always_comb begin
    o_apb     = '0;
    o_start   = 1'b0;
    status_rd = 1'b0;
    if (access) begin
      if (hit_ctrl) begin
        o_apb.pready = 1'b1;
        if (i_apb.pwrite && i_apb.pwdata[mm_bus_pkg::CTRL_START_BIT]) begin
          // start during a run is refused
          if (i_busy) begin
            o_apb.pslverr = 1'b1;
          end else begin
            o_start = 1'b1;
          end
        end
      end else if (hit_status) begin
        o_apb.pready = 1'b1;
        o_apb.prdata[mm_bus_pkg::STATUS_BUSY_BIT] = i_busy;
        o_apb.prdata[mm_bus_pkg::STATUS_DONE_BIT] = done_q;
        status_rd = !i_apb.pwrite;
      end else if (hit_opnd) begin
        // completes the cycle after the grant, with the memory read data
        o_apb.pready = gnt_q;
        if (gnt_q && !i_apb.pwrite && i_rd_owner) begin
          o_apb.prdata = i_rd_data;
        end
      end else if (hit_res) begin
        o_apb.pready = 1'b1;
        if (!i_apb.pwrite) begin
          o_apb.prdata = res_q[res_off[2 +: mm_cfg_pkg::MM_NW]];
        end
      end else begin
        o_apb.pready  = 1'b1;
        o_apb.pslverr = 1'b1;
      end
    end
  end

  // run end is the falling edge of busy
  assign o_irq = busy_q && !i_busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      done_q <= 1'b0;
      busy_q <= 1'b0;
      gnt_q  <= 1'b0;
      res_q  <= '0;
    end else begin
      busy_q <= i_busy;
      gnt_q  <= o_host_req.valid && i_host_gnt;
      // a new completion beats a clear from the same read
      if (o_irq) begin
        done_q <= 1'b1;
      end else if (status_rd) begin
        done_q <= 1'b0;
      end
      if (i_res_valid) begin
        res_q <= i_res;
      end
    end
  end

endmodule

/* src/mm_operand_mem.sv */
`timescale 1ns/1ps

module mm_operand_mem (
  input  logic                 clk,
  input  mm_bus_pkg::mem_req_t i_req,
  output mm_cfg_pkg::mm_lane_t o_rd_data
);

  mm_cfg_pkg::mm_lane_t mem_q [mm_cfg_pkg::MM_MEM_DEPTH];
  mm_cfg_pkg::mm_lane_t rd_q;

  // single port, read data registered
  always_ff @(posedge clk) begin
    if (i_req.valid) begin
      if (i_req.write) begin
        mem_q[i_req.addr] <= i_req.wdata;
      end else begin
        rd_q <= mem_q[i_req.addr];
      end
    end
  end

  assign o_rd_data = rd_q;

endmodule

/* src/mm_mem_arbiter.sv */
`timescale 1ns/1ps

module mm_mem_arbiter (
  input  logic                 clk,
  input  logic                 reset,
  input  mm_bus_pkg::mem_req_t i_eng_req,
  input  mm_bus_pkg::mem_req_t i_host_req,
  output logic                 o_eng_gnt,
  output logic                 o_host_gnt,
  output mm_bus_pkg::mem_req_t o_mem_req,
  output logic                 o_rd_owner
);

  logic rd_owner_q;

  // engine always wins, host only gets idle cycles
  assign o_eng_gnt  = i_eng_req.valid;
  assign o_host_gnt = i_host_req.valid && !i_eng_req.valid;

  always_comb begin
    if (i_eng_req.valid) begin
      o_mem_req = i_eng_req;
    end else begin
      o_mem_req = i_host_req;
    end
  end

  // 1 means the pending read belongs to the host
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_owner_q <= 1'b0;
    end else if (o_mem_req.valid && !o_mem_req.write) begin
      rd_owner_q <= o_host_gnt;
    end
  end

  assign o_rd_owner = rd_owner_q;

endmodule

/* src/mm_operand_fetch.sv */
`timescale 1ns/1ps

module mm_operand_fetch (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_start,
  output mm_bus_pkg::mem_req_t o_eng_req,
  input  logic                 i_eng_gnt,
  input  mm_cfg_pkg::mm_lane_t i_rd_data,
  output logic                 o_busy,
  output logic                 o_clear,
  output logic                 o_beat_valid,
  output mm_cfg_pkg::mm_lane_t o_beat_a,
  output mm_cfg_pkg::mm_lane_t o_beat_b,
  input  logic                 i_res_valid
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_STREAM,
    ST_WAIT
  } state_t;

  state_t               state_q;
  mm_cfg_pkg::mm_addr_t cnt_q;
  logic                 rd_pend_q;
  mm_cfg_pkg::mm_addr_t rd_addr_q;
  mm_cfg_pkg::mm_lane_t opnd_q [mm_cfg_pkg::MM_MEM_DEPTH];

  always_comb begin
    o_eng_req       = '0;
    o_eng_req.valid = (state_q == ST_FETCH);
    o_eng_req.addr  = cnt_q;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q   <= ST_IDLE;
      cnt_q     <= '0;
      rd_pend_q <= 1'b0;
      rd_addr_q <= '0;
    end else begin
      rd_pend_q <= o_eng_req.valid && i_eng_gnt;
      rd_addr_q <= cnt_q;
      case (state_q)
        ST_IDLE: begin
          if (i_start) begin
            state_q <= ST_FETCH;
            cnt_q   <= '0;
          end
        end
        ST_FETCH: begin
          if (i_eng_gnt) begin
            if (cnt_q == mm_cfg_pkg::mm_addr_t'(mm_cfg_pkg::MM_MEM_DEPTH - 1)) begin
              state_q <= ST_STREAM;
              cnt_q   <= '0;
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
        end
        ST_STREAM: begin
          if (cnt_q == mm_cfg_pkg::mm_addr_t'(mm_cfg_pkg::MM_N - 1)) begin
            state_q <= ST_WAIT;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        ST_WAIT: begin
          if (i_res_valid) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // read data lands one cycle after the granted request
  always_ff @(posedge clk) begin
    if (rd_pend_q) begin
      opnd_q[rd_addr_q] <= i_rd_data;
    end
  end

  // beat t pairs A column t with B row t
  assign o_beat_valid = (state_q == ST_STREAM);
  assign o_beat_a     = opnd_q[cnt_q];
  assign o_beat_b     = opnd_q[cnt_q + mm_cfg_pkg::mm_addr_t'(mm_cfg_pkg::MM_N)];

  assign o_busy  = (state_q != ST_IDLE);
  assign o_clear = (state_q == ST_IDLE) && i_start;

endmodule

/* src/mm_systolic_array.sv */
`timescale 1ns/1ps

module mm_systolic_array (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_beat_valid,
  input  logic                 i_clear,
  input  mm_cfg_pkg::mm_lane_t i_beat_a,
  input  mm_cfg_pkg::mm_lane_t i_beat_b,
  output logic                 o_res_valid,
  output mm_cfg_pkg::mm_res_t  o_res
);

  mm_cfg_pkg::mm_lane_t a_in;
  mm_cfg_pkg::mm_lane_t b_in;
  mm_cfg_pkg::mm_lane_t a_dly [1:mm_cfg_pkg::MM_N-1];
  mm_cfg_pkg::mm_lane_t b_dly [1:mm_cfg_pkg::MM_N-1];

  // a moves right, b moves down
  mm_cfg_pkg::mm_elem_t a_h [mm_cfg_pkg::MM_N][mm_cfg_pkg::MM_N+1];
  mm_cfg_pkg::mm_elem_t b_v [mm_cfg_pkg::MM_N+1][mm_cfg_pkg::MM_N];
  mm_cfg_pkg::mm_elem_t c_grid [mm_cfg_pkg::MM_N][mm_cfg_pkg::MM_N];

  logic                    run_q;
  mm_cfg_pkg::mm_run_cnt_t cnt_q;
  logic                    res_valid_q;
  mm_cfg_pkg::mm_res_t     res_q;

  // idle beats carry zeros so no stray products reach the accumulators
  assign a_in = i_beat_valid ? i_beat_a : '0;
  assign b_in = i_beat_valid ? i_beat_b : '0;

  // skew lines, stage d holds the lane d cycles late
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int d = 1; d < mm_cfg_pkg::MM_N; d++) begin
        a_dly[d] <= '0;
        b_dly[d] <= '0;
      end
    end else begin
      a_dly[1] <= a_in;
      b_dly[1] <= b_in;
      for (int d = 2; d < mm_cfg_pkg::MM_N; d++) begin
        a_dly[d] <= a_dly[d-1];
        b_dly[d] <= b_dly[d-1];
      end
    end
  end

  for (genvar i = 0; i < mm_cfg_pkg::MM_N; i++) begin : g_row
    // row i of a and column i of b enter i cycles late
    if (i == 0) begin : g_edge
      assign a_h[i][0] = a_in[i];
      assign b_v[0][i] = b_in[i];
    end else begin : g_skew
      assign a_h[i][0] = a_dly[i][i];
      assign b_v[0][i] = b_dly[i][i];
    end

    for (genvar j = 0; j < mm_cfg_pkg::MM_N; j++) begin : g_col
      mm_pe u_pe (
        .clk     (clk),
        .reset   (reset),
        .i_a     (a_h[i][j]),
        .i_b     (b_v[i][j]),
        .i_clear (i_clear),
        .o_a     (a_h[i][j+1]),
        .o_b     (b_v[i+1][j]),
        .o_c     (c_grid[i][j])
      );
    end
  end

  // run counter, cnt_q equals k in the k-th cycle after the first beat
  always_ff @(posedge clk) begin
    if (reset) begin
      run_q       <= 1'b0;
      cnt_q       <= '0;
      res_valid_q <= 1'b0;
      res_q       <= '0;
    end else begin
      res_valid_q <= 1'b0;
      if (!run_q) begin
        if (i_beat_valid) begin
          run_q <= 1'b1;
          cnt_q <= mm_cfg_pkg::mm_run_cnt_t'(1);
        end
      end else if (cnt_q == mm_cfg_pkg::mm_run_cnt_t'(mm_cfg_pkg::MM_DRAIN - 1)) begin
        run_q       <= 1'b0;
        cnt_q       <= '0;
        res_valid_q <= 1'b1;
        for (int i = 0; i < mm_cfg_pkg::MM_N; i++) begin
          for (int j = 0; j < mm_cfg_pkg::MM_N; j++) begin
            res_q[i][j] <= c_grid[i][j];
          end
        end
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign o_res_valid = res_valid_q;
  assign o_res       = res_q;

endmodule

/* src/mm_pe.sv */
`timescale 1ns/1ps

module mm_pe (
  input  logic                 clk,
  input  logic                 reset,
  input  mm_cfg_pkg::mm_elem_t i_a,
  input  mm_cfg_pkg::mm_elem_t i_b,
  input  logic                 i_clear,
  output mm_cfg_pkg::mm_elem_t o_a,
  output mm_cfg_pkg::mm_elem_t o_b,
  output mm_cfg_pkg::mm_elem_t o_c
);

  mm_cfg_pkg::mm_elem_t a_q;
  mm_cfg_pkg::mm_elem_t b_q;
  mm_cfg_pkg::mm_prod_t prod_q;
  mm_cfg_pkg::mm_elem_t sat;
  mm_cfg_pkg::mm_elem_t acc_q;
  logic [mm_cfg_pkg::MM_DW:0] prod_hi;

  // sign bit plus everything above the int8 range
  assign prod_hi = prod_q[2*mm_cfg_pkg::MM_DW-1 -: mm_cfg_pkg::MM_DW+1];

  // clamp the product to int8
  always_comb begin
    if (prod_hi == '0 || prod_hi == '1) begin
      sat = prod_q[mm_cfg_pkg::MM_DW-1:0];
    end else if (prod_q[2*mm_cfg_pkg::MM_DW-1]) begin
      sat = {1'b1, {(mm_cfg_pkg::MM_DW-1){1'b0}}};
    end else begin
      sat = {1'b0, {(mm_cfg_pkg::MM_DW-1){1'b1}}};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      a_q    <= '0;
      b_q    <= '0;
      prod_q <= '0;
      acc_q  <= '0;
    end else begin
      a_q    <= i_a;
      b_q    <= i_b;
      prod_q <= a_q * b_q;
      // wrapping 8-bit sum
      if (i_clear) begin
        acc_q <= '0;
      end else begin
        acc_q <= acc_q + sat;
      end
    end
  end

  assign o_a = a_q;
  assign o_b = b_q;
  assign o_c = acc_q;

endmodule

/* src/mm_bus_pkg.sv */
package mm_bus_pkg;

  localparam int APB_AW = 8;
  localparam int APB_DW = 32;

  typedef logic [APB_AW-1:0] apb_addr_t;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    apb_addr_t         paddr;
    logic [APB_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // one access to the shared operand memory
  typedef struct packed {
    logic                 valid;
    logic                 write;
    mm_cfg_pkg::mm_addr_t addr;
    mm_cfg_pkg::mm_lane_t wdata;
  } mem_req_t;

  // register map
  localparam apb_addr_t REG_CTRL      = 8'h00;
  localparam apb_addr_t REG_STATUS    = 8'h04;
  localparam apb_addr_t REG_OPND_BASE = 8'h10;
  localparam apb_addr_t REG_RES_BASE  = 8'h30;
  localparam apb_addr_t REG_OPND_END  =
    REG_OPND_BASE + apb_addr_t'(4 * mm_cfg_pkg::MM_MEM_DEPTH);
  localparam apb_addr_t REG_RES_END   = REG_RES_BASE + apb_addr_t'(4 * mm_cfg_pkg::MM_N);

  localparam int CTRL_START_BIT  = 0;
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

endpackage

/* src/mm_cfg_pkg.sv */
package mm_cfg_pkg;

  // array geometry and element width
  localparam int MM_N  = 4;
  localparam int MM_NW = $clog2(MM_N);
  localparam int MM_DW = 8;

  // operand memory holds the A columns then the B rows
  localparam int MM_MEM_DEPTH = 2 * MM_N;
  localparam int MM_MEM_AW    = $clog2(MM_MEM_DEPTH);

  // pe pipeline is input reg, product reg, accumulator
  localparam int MM_MAC_LAT = 3;

  // first streamed beat to result capture
  localparam int MM_DRAIN  = 3 * MM_N + MM_MAC_LAT;
  localparam int MM_RUN_CW = $clog2(MM_DRAIN + 1);

  typedef logic signed [MM_DW-1:0]   mm_elem_t;
  typedef logic signed [2*MM_DW-1:0] mm_prod_t;

  // one memory word, element k in byte k
  typedef mm_elem_t [MM_N-1:0] mm_lane_t;

  // result matrix, row i is lane i
  typedef mm_lane_t [MM_N-1:0] mm_res_t;

  typedef logic [MM_MEM_AW-1:0] mm_addr_t;
  typedef logic [MM_RUN_CW-1:0] mm_run_cnt_t;

endpackage
